// File: hdl/dsi_tx_lane_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_lane_ctrl
    import dsi_tx_pkg::*;
(
    input  wire                             clk_phy,
    input  wire                             rst_n,
    input  wire lane_mask_t                 lane_mask,
    input  wire [LANES_MAX-1:0][BYTE_W:0]   lane_rd_data,
    input  wire lane_mask_t                 lane_empty,
    output lane_mask_t                      lane_rd,
    output lane_byte_t [LANES_MAX-1:0]      hs_data,
    output lane_mask_t                      hs_valid,
    output lane_mask_t                      hs_active
);

    lane_state_t state;
    lane_mask_t  active;     // lanes still inside their burst
    lane_mask_t  last_pop;
    logic        start;

    // every masked lane holds at least one byte
    assign start     = (lane_mask != '0) && ((lane_mask & lane_empty) == '0);
    assign lane_rd   = (state == LANE_BURST) ? (active & ~lane_empty) : '0;
    assign hs_valid  = (state == LANE_SYNC) ? active : lane_rd;
    assign hs_active = active;

    always_comb begin
        for (int i = 0; i < LANES_MAX; i++) begin
            last_pop[i] = lane_rd[i] & lane_rd_data[i][BYTE_W];
            hs_data[i]  = (state == LANE_SYNC) ? HS_SYNC_BYTE : lane_rd_data[i][BYTE_W-1:0];
        end
    end

    always_ff @(posedge clk_phy or negedge rst_n) begin
        if (!rst_n) begin
            state  <= LANE_IDLE;
            active <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (start) begin
                        state  <= LANE_SYNC;
                        active <= lane_mask;   // mask held for the whole burst
                    end
                end
                LANE_SYNC: begin
                    state <= LANE_BURST;
                end
                LANE_BURST: begin
                    active <= active & ~last_pop;
                    if (active == '0) begin
                        state <= LANE_IDLE;
                    end
                end
                default: begin
                    state <= LANE_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/dsi_tx_lane_distributor.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_lane_distributor
    import dsi_tx_pkg::*;
(
    input  wire                           clk_phy,
    input  wire                           rst_n,
    input  wire lane_num_t                lanes_number,
    input  wire lane_byte_t               pkt_byte,
    input  wire                           pkt_valid,
    output logic                          pkt_ready,
    output logic [LANES_MAX-1:0][BYTE_W:0] lane_wr_data,
    output lane_mask_t                    lane_wr,
    input  wire lane_mask_t               lane_full,
    output lane_mask_t                    lane_mask
);

    logic [BYTE_CNT_W-1:0] byte_idx;
    logic [LANE_IDX_W-1:0] cur_lane;
    lane_num_t             lanes_q;
    lane_num_t             lanes_eff;
    logic                  xfer;
    logic                  last_byte;
    logic                  pkt_last;

    assign lanes_eff = (byte_idx == '0) ? lanes_number : lanes_q;   // live at byte 0
    assign last_byte = byte_idx >= BYTE_CNT_W'(PACKET_BYTES) - BYTE_CNT_W'(lanes_eff);
    assign pkt_last  = (byte_idx == BYTE_CNT_W'(PACKET_BYTES - 1));
    assign pkt_ready = ~lane_full[cur_lane];
    assign xfer      = pkt_valid & pkt_ready;
    assign lane_wr   = lane_mask_t'(xfer) << cur_lane;

    always_comb begin
        for (int i = 0; i < LANES_MAX; i++) begin
            lane_wr_data[i] = {last_byte, pkt_byte};
        end
    end

    always_ff @(posedge clk_phy or negedge rst_n) begin
        if (!rst_n) begin
            byte_idx  <= '0;
            cur_lane  <= '0;
            lanes_q   <= '0;
            lane_mask <= '0;
        end else if (xfer) begin
            byte_idx <= pkt_last ? '0 : byte_idx + 1'b1;
            if (pkt_last || cur_lane == LANE_IDX_W'(lanes_eff - 1'b1)) begin
                cur_lane <= '0;
            end else begin
                cur_lane <= cur_lane + 1'b1;
            end
            if (byte_idx == '0) begin
                lanes_q   <= lanes_number;
                lane_mask <= ~(lane_mask_t'('1) << lanes_number);   // low N lanes
            end
        end
    end

    lanes_in_range: assert property (@(posedge clk_phy) disable iff (!rst_n)
        byte_idx != '0 |-> lanes_q inside {[1:LANES_MAX]});

endmodule

`default_nettype wire

// File: hdl/dsi_tx_lane_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_lane_fifo
    import dsi_tx_pkg::*;
(
    input  wire              clk_phy,
    input  wire              rst_n,
    input  wire [BYTE_W:0]   wr_data,   // last flag on top
    input  wire              wr,
    output logic             full,
    output logic [BYTE_W:0]  rd_data,
    input  wire              rd,
    output logic             empty
);

    logic [BYTE_W:0]       mem [LANE_FIFO_DEPTH];
    logic [LANE_PTR_W-1:0] wr_ptr;
    logic [LANE_PTR_W-1:0] rd_ptr;
    logic [LANE_PTR_W:0]   count;

    assign full    = (count == (LANE_PTR_W+1)'(LANE_FIFO_DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];   // head always visible

    always_ff @(posedge clk_phy) begin
        if (wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_phy or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    no_write_when_full: assert property (@(posedge clk_phy) disable iff (!rst_n)
        wr |-> !full);

    no_read_when_empty: assert property (@(posedge clk_phy) disable iff (!rst_n)
        rd |-> !empty);

endmodule

`default_nettype wire

// File: hdl/dsi_tx_line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_line_buffer
    import dsi_tx_pkg::*;
(
    input  wire            clk_phy,
    input  wire            rst_n,
    input  wire pix_word_t pix_data,
    input  wire            pix_eol,
    input  wire            pix_valid,
    output logic           pix_ready,
    output pix_word_t      word_data,
    output logic           word_valid,
    input  wire            word_ready,
    output logic           line_ready
);

    pix_word_t             mem [LINE_FIFO_DEPTH];
    logic [LINE_PTR_W-1:0] wr_ptr;
    logic [LINE_PTR_W-1:0] rd_ptr;
    logic [LINE_PTR_W:0]   count;
    logic [LINE_PTR_W:0]   count_nxt;
    logic [WORD_IDX_W-1:0] wr_idx;   // word position within the incoming line
    logic [WORD_IDX_W-1:0] rd_idx;
    logic [1:0]            line_cnt;
    logic                  wr_en;
    logic                  rd_en;
    logic                  line_in;
    logic                  line_out;

    assign wr_en      = pix_valid & pix_ready;
    assign rd_en      = word_valid & word_ready;
    assign line_in    = wr_en & pix_eol;
    assign line_out   = rd_en & (rd_idx == WORD_IDX_W'(LINE_WORDS - 1));
    assign word_valid = (count != '0);
    assign word_data  = mem[rd_ptr];   // show-ahead
    assign line_ready = (line_cnt != '0);

    always_comb begin
        case ({wr_en, rd_en})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    always_ff @(posedge clk_phy) begin
        if (wr_en) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk_phy or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            wr_idx    <= '0;
            rd_idx    <= '0;
            line_cnt  <= '0;
            pix_ready <= 1'b0;
        end else begin
            count     <= count_nxt;
            pix_ready <= (count_nxt != (LINE_PTR_W+1)'(LINE_FIFO_DEPTH));
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                wr_idx <= wr_idx + 1'b1;   // wraps at line end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_idx <= rd_idx + 1'b1;
            end
            case ({line_in, line_out})
                2'b10:   line_cnt <= line_cnt + 1'b1;
                2'b01:   line_cnt <= line_cnt - 1'b1;
                default: line_cnt <= line_cnt;
            endcase
        end
    end

    eol_on_last_word: assert property (@(posedge clk_phy) disable iff (!rst_n)
        line_in |-> wr_idx == WORD_IDX_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: hdl/dsi_tx_packet_assembler.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_packet_assembler
    import dsi_tx_pkg::*;
(
    input  wire            clk_phy,
    input  wire            rst_n,
    input  wire            enable,
    input  wire            line_ready,
    input  wire pix_word_t word_data,
    input  wire            word_valid,
    output logic           word_ready,
    output lane_byte_t     pkt_byte,
    output logic           pkt_valid,
    input  wire            pkt_ready
);

    asm_state_t            state;
    logic [BYTE_CNT_W-1:0] byte_cnt;   // byte index within the current section
    logic                  xfer;
    logic                  phase_done;
    word_count_t           word_count;
    ecc_t                  hdr_ecc;

    assign word_count = word_count_t'(LINE_BYTES);
    assign hdr_ecc    = dsi_ecc({word_count, DI_LONG_PACKET});

    assign pkt_valid  = (state != ASM_IDLE);
    assign xfer       = pkt_valid & pkt_ready;
    // pop the word once its top byte is taken
    assign word_ready = xfer && (state == ASM_PAYLOAD) && (byte_cnt[1:0] == 2'd3);

    always_comb begin
        case (state)
            ASM_HEADER:  phase_done = (byte_cnt == BYTE_CNT_W'(HEADER_BYTES - 1));
            ASM_PAYLOAD: phase_done = (byte_cnt == BYTE_CNT_W'(LINE_BYTES - 1));
            ASM_FOOTER:  phase_done = (byte_cnt == BYTE_CNT_W'(FOOTER_BYTES - 1));
            default:     phase_done = 1'b0;
        endcase
    end

    always_comb begin
        pkt_byte = '0;   // footer is sent as zero
        case (state)
            ASM_HEADER: begin
                case (byte_cnt[1:0])
                    2'd0:    pkt_byte = DI_LONG_PACKET;
                    2'd1:    pkt_byte = word_count[7:0];
                    2'd2:    pkt_byte = word_count[15:8];
                    default: pkt_byte = hdr_ecc;
                endcase
            end
            ASM_PAYLOAD: pkt_byte = word_data[byte_cnt[1:0]*BYTE_W +: BYTE_W];   // low byte first
            default:     pkt_byte = '0;
        endcase
    end

    always_ff @(posedge clk_phy or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ASM_IDLE;
            byte_cnt <= '0;
        end else begin
            if (state == ASM_IDLE) begin
                if (enable && line_ready) begin
                    state <= ASM_HEADER;
                end
            end else if (xfer) begin
                byte_cnt <= phase_done ? '0 : byte_cnt + 1'b1;
                if (phase_done) begin
                    case (state)
                        ASM_HEADER:  state <= ASM_PAYLOAD;
                        ASM_PAYLOAD: state <= ASM_FOOTER;
                        default:     state <= ASM_IDLE;
                    endcase
                end
            end
        end
    end

    // a full line is stored before the header starts
    payload_words_present: assert property (@(posedge clk_phy) disable iff (!rst_n)
        state == ASM_PAYLOAD |-> word_valid);

endmodule

`default_nettype wire

// File: hdl/dsi_tx_pkg.sv
`default_nettype none

package dsi_tx_pkg;

    localparam int PIX_WORD_W      = 32;
    localparam int BYTE_W          = 8;
    localparam int LANES_MAX       = 4;
    localparam int LINE_WIDTH      = 64;   // pixels
    localparam int BITS_PER_PIXEL  = 8;
    localparam int LINE_BYTES      = LINE_WIDTH * BITS_PER_PIXEL / BYTE_W;
    localparam int LINE_WORDS      = LINE_BYTES * BYTE_W / PIX_WORD_W;
    localparam int HEADER_BYTES    = 4;
    localparam int FOOTER_BYTES    = 2;
    localparam int PACKET_BYTES    = HEADER_BYTES + LINE_BYTES + FOOTER_BYTES;
    localparam int LINE_FIFO_DEPTH = 2 * LINE_WORDS;   // room for two lines
    localparam int LANE_FIFO_DEPTH = 16;

    localparam int LINE_PTR_W = $clog2(LINE_FIFO_DEPTH);
    localparam int LANE_PTR_W = $clog2(LANE_FIFO_DEPTH);
    localparam int WORD_IDX_W = $clog2(LINE_WORDS);
    localparam int LANE_IDX_W = $clog2(LANES_MAX);
    localparam int BYTE_CNT_W = $clog2(PACKET_BYTES);

    typedef logic [PIX_WORD_W-1:0] pix_word_t;
    typedef logic [BYTE_W-1:0]     lane_byte_t;
    typedef logic [2:0]            lane_num_t;
    typedef logic [LANES_MAX-1:0]  lane_mask_t;
    typedef logic [15:0]           word_count_t;
    typedef logic [7:0]            ecc_t;

    localparam lane_byte_t DI_LONG_PACKET = 8'h29;   // generic long write
    localparam lane_byte_t HS_SYNC_BYTE   = 8'hB8;

    typedef enum logic [1:0] {ASM_IDLE, ASM_HEADER, ASM_PAYLOAD, ASM_FOOTER} asm_state_t;
    typedef enum logic [1:0] {LANE_IDLE, LANE_SYNC, LANE_BURST} lane_state_t;

    // hamming parity over DI and word count with bits 7:6 held at zero
    function automatic ecc_t dsi_ecc(input logic [23:0] d);
        ecc_t p;
        p    = '0;
        p[0] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[13]
             ^ d[16] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[1] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[12] ^ d[14]
             ^ d[17] ^ d[20] ^ d[21] ^ d[22] ^ d[23];
        p[2] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[11] ^ d[12] ^ d[15]
             ^ d[18] ^ d[20] ^ d[21] ^ d[22];
        p[3] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[13] ^ d[14] ^ d[15]
             ^ d[19] ^ d[20] ^ d[21] ^ d[23];
        p[4] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[22] ^ d[23];
        p[5] = d[10] ^ d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17]
             ^ d[18] ^ d[19] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

endpackage

`default_nettype wire

// File: hdl/dsi_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_top
    import dsi_tx_pkg::*;
(
    input  wire                         clk_phy,
    input  wire                         rst_n,
    input  wire                         enable,
    input  wire lane_num_t              lanes_number,
    input  wire pix_word_t              pix_data,
    input  wire                         pix_eol,
    input  wire                         pix_valid,
    output logic                        pix_ready,
    output lane_byte_t [LANES_MAX-1:0]  hs_data,
    output lane_mask_t                  hs_valid,
    output lane_mask_t                  hs_active
);

    pix_word_t                     word_data;
    logic                          word_valid;
    logic                          word_ready;
    logic                          line_ready;
    lane_byte_t                    pkt_byte;
    logic                          pkt_valid;
    logic                          pkt_ready;
    logic [LANES_MAX-1:0][BYTE_W:0] lane_wr_data;
    logic [LANES_MAX-1:0][BYTE_W:0] lane_rd_data;
    lane_mask_t                    lane_wr;
    lane_mask_t                    lane_full;
    lane_mask_t                    lane_rd;
    lane_mask_t                    lane_empty;
    lane_mask_t                    lane_mask;

    dsi_tx_line_buffer dsi_tx_line_buffer_0 (
        .clk_phy    (clk_phy),
        .rst_n      (rst_n),
        .pix_data   (pix_data),
        .pix_eol    (pix_eol),
        .pix_valid  (pix_valid),
        .pix_ready  (pix_ready),
        .word_data  (word_data),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .line_ready (line_ready)
    );

    dsi_tx_packet_assembler dsi_tx_packet_assembler_0 (
        .clk_phy    (clk_phy),
        .rst_n      (rst_n),
        .enable     (enable),
        .line_ready (line_ready),
        .word_data  (word_data),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .pkt_byte   (pkt_byte),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready)
    );

    dsi_tx_lane_distributor dsi_tx_lane_distributor_0 (
        .clk_phy      (clk_phy),
        .rst_n        (rst_n),
        .lanes_number (lanes_number),
        .pkt_byte     (pkt_byte),
        .pkt_valid    (pkt_valid),
        .pkt_ready    (pkt_ready),
        .lane_wr_data (lane_wr_data),
        .lane_wr      (lane_wr),
        .lane_full    (lane_full),
        .lane_mask    (lane_mask)
    );

    for (genvar i = 0; i < LANES_MAX; i++) begin : g_lane_fifo
        dsi_tx_lane_fifo dsi_tx_lane_fifo_i (
            .clk_phy (clk_phy),
            .rst_n   (rst_n),
            .wr_data (lane_wr_data[i]),
            .wr      (lane_wr[i]),
            .full    (lane_full[i]),
            .rd_data (lane_rd_data[i]),
            .rd      (lane_rd[i]),
            .empty   (lane_empty[i])
        );
    end

    dsi_tx_lane_ctrl dsi_tx_lane_ctrl_0 (
        .clk_phy      (clk_phy),
        .rst_n        (rst_n),
        .lane_mask    (lane_mask),
        .lane_rd_data (lane_rd_data),
        .lane_empty   (lane_empty),
        .lane_rd      (lane_rd),
        .hs_data      (hs_data),
        .hs_valid     (hs_valid),
        .hs_active    (hs_active)
    );

endmodule

`default_nettype wire

// File: project.f
hdl/dsi_tx_pkg.sv
hdl/dsi_tx_line_buffer.sv
hdl/dsi_tx_packet_assembler.sv
hdl/dsi_tx_lane_distributor.sv
hdl/dsi_tx_lane_fifo.sv
hdl/dsi_tx_lane_ctrl.sv
hdl/dsi_tx_top.sv
tests/dsi_tx_tb.sv

// File: tests/dsi_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dsi_tx_tb
    import dsi_tx_pkg::*;
;

    localparam int          CLK_PERIOD  = 100;
    localparam int          NUM_ROWS    = 8;
    localparam int          EXP_DEPTH   = 512;   // per lane, per row
    localparam int          HOLD_CYCLES = 30;
    localparam int unsigned SEED        = 32'h966939f3;

    // syndrome code of each header bit from D23 down
    localparam logic [24*6-1:0] ECC_CODES = {
        6'h3B, 6'h37, 6'h2F, 6'h1F, 6'h38, 6'h34, 6'h32, 6'h31,
        6'h2C, 6'h2A, 6'h29, 6'h26, 6'h25, 6'h23, 6'h1C, 6'h1A,
        6'h19, 6'h16, 6'h15, 6'h13, 6'h0E, 6'h0D, 6'h0B, 6'h07
    };

    logic                       clk_phy;
    logic                       rst_n;
    logic                       enable;
    lane_num_t                  lanes_number;
    pix_word_t                  pix_data;
    logic                       pix_eol;
    logic                       pix_valid;
    logic                       pix_ready;
    lane_byte_t [LANES_MAX-1:0] hs_data;
    lane_mask_t                 hs_valid;
    lane_mask_t                 hs_active;

    // test rows of lanes, lines, pixel base, input stalls and enable held low
    int        row_lanes [NUM_ROWS] = '{2, 1, 2, 4, 3, 4, 1, 2};
    int        row_lines [NUM_ROWS] = '{2, 1, 1, 1, 2, 3, 3, 4};
    pix_word_t row_base  [NUM_ROWS] = '{32'h1000_0000, 32'h2000_0011, 32'h3000_0022,
                                        32'h4000_0033, 32'h5000_0044, 32'h6000_0055,
                                        32'h7000_0066, 32'h8000_0077};
    bit        row_stall [NUM_ROWS] = '{0, 0, 0, 0, 1, 1, 1, 1};
    bit        row_hold  [NUM_ROWS] = '{1, 0, 0, 0, 0, 0, 0, 0};

    lane_byte_t exp_mem [LANES_MAX][EXP_DEPTH];
    int         exp_wr [LANES_MAX];
    int         exp_rd [LANES_MAX];
    int         burst_cnt [LANES_MAX];
    lane_mask_t exp_mask;
    int         exp_lanes;
    lane_mask_t prev_active;
    lane_mask_t done_prev;
    int         data_err;
    int         proto_err;
    int         timeout_err;

    dsi_tx_top dsi_tx_top_i (
        .clk_phy      (clk_phy),
        .rst_n        (rst_n),
        .enable       (enable),
        .lanes_number (lanes_number),
        .pix_data     (pix_data),
        .pix_eol      (pix_eol),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .hs_data      (hs_data),
        .hs_valid     (hs_valid),
        .hs_active    (hs_active)
    );

    initial begin
        clk_phy = 1'b0;
        forever #(CLK_PERIOD / 2) clk_phy = ~clk_phy;
    end

    function automatic ecc_t header_ecc(input logic [23:0] hdr);
        ecc_t e;
        e = '0;
        for (int i = 0; i < 24; i++) begin
            if (hdr[i]) begin
                e[5:0] = e[5:0] ^ ECC_CODES[6*i +: 6];
            end
        end
        return e;
    endfunction

    function automatic pix_word_t pixel_word(input pix_word_t base, input int idx);
        return base + pix_word_t'(idx) * 32'h0103_0507;
    endfunction

    // sync byte plus the bytes k with k mod n == q
    function automatic int burst_len(input int n, input int q);
        int cnt;
        cnt = 1;
        for (int k = 0; k < PACKET_BYTES; k++) begin
            if (k % n == q) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic load_expected(input int n, input int lines, input pix_word_t base);
        lane_byte_t pkt [PACKET_BYTES];
        pix_word_t  w;
        int         q;
        for (int i = 0; i < LANES_MAX; i++) begin
            exp_wr[i] = 0;
            exp_rd[i] = 0;
        end
        for (int l = 0; l < lines; l++) begin
            pkt[0] = 8'h29;   // generic long write
            pkt[1] = 8'h40;   // 64 payload bytes
            pkt[2] = 8'h00;
            pkt[3] = header_ecc(24'h00_40_29);
            for (int b = 0; b < 64; b++) begin
                w          = pixel_word(base, l * 16 + b / 4);
                pkt[4 + b] = w[8 * (b % 4) +: 8];
            end
            pkt[68] = 8'h00;
            pkt[69] = 8'h00;
            for (int i = 0; i < n; i++) begin
                exp_mem[i][exp_wr[i]] = 8'hB8;
                exp_wr[i]++;
            end
            for (int k = 0; k < PACKET_BYTES; k++) begin
                q                     = k % n;
                exp_mem[q][exp_wr[q]] = pkt[k];
                exp_wr[q]++;
            end
        end
        exp_lanes = n;
    endtask

    task automatic send_words(input int n_words, input pix_word_t base, input bit stall);
        int idx;
        bit took;
        idx  = 0;
        took = 1'b0;
        while (idx < n_words) begin
            @(negedge clk_phy);
            if (took) begin
                idx++;
            end
            if (idx < n_words) begin
                if (!pix_valid || took) begin   // free to pick a new valid level
                    pix_valid = !(stall && ($urandom % 3 == 0));
                end
                pix_data = pixel_word(base, idx);
                pix_eol  = (idx % 16 == 15);
                took     = pix_valid && pix_ready;
            end else begin
                pix_valid = 1'b0;
                pix_eol   = 1'b0;
            end
        end
    endtask

    function automatic bit row_done(input int n);
        bit done;
        done = (prev_active == '0);
        for (int i = 0; i < n; i++) begin
            if (exp_rd[i] != exp_wr[i]) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    task automatic run_row(input int r);
        lane_mask_t mask;
        mask = lane_mask_t'((1 << row_lanes[r]) - 1);
        @(posedge clk_phy);
        load_expected(row_lanes[r], row_lines[r], row_base[r]);
        exp_mask = row_hold[r] ? lane_mask_t'(0) : mask;
        @(negedge clk_phy);
        lanes_number = lane_num_t'(row_lanes[r]);
        enable       = !row_hold[r];
        send_words(row_lines[r] * 16, row_base[r], row_stall[r]);
        if (row_hold[r]) begin
            repeat (HOLD_CYCLES) @(negedge clk_phy);   // lines stored and nothing may leave
            @(posedge clk_phy);
            exp_mask = mask;
            @(negedge clk_phy);
            enable = 1'b1;
        end
        @(posedge clk_phy);
        while (!row_done(row_lanes[r])) begin
            @(posedge clk_phy);
        end
    endtask

    task automatic sample_outputs();
        lane_mask_t rose;
        lane_mask_t fell;
        rose = hs_active & ~prev_active;
        fell = prev_active & ~hs_active;
        assert ((hs_valid & ~exp_mask) == '0) else begin
            $display("FAIL t=%0t hs_valid (unmasked lanes): expected %b, got %b",
                     $time, 4'b0000, hs_valid & ~exp_mask);
            proto_err++;
        end
        assert ((hs_active & ~exp_mask) == '0) else begin
            $display("FAIL t=%0t hs_active (unmasked lanes): expected %b, got %b",
                     $time, 4'b0000, hs_active & ~exp_mask);
            proto_err++;
        end
        if (rose != '0) begin
            assert (prev_active == '0) else begin
                $display("lane burst started at t=%0t while another lane was still active",
                         $time);
                proto_err++;
            end
            assert (hs_active == exp_mask) else begin
                $display("FAIL t=%0t hs_active at sync: expected %b, got %b",
                         $time, exp_mask, hs_active);
                proto_err++;
            end
            assert (hs_valid == exp_mask) else begin
                $display("FAIL t=%0t hs_valid at sync: expected %b, got %b",
                         $time, exp_mask, hs_valid);
                proto_err++;
            end
            for (int q = 0; q < LANES_MAX; q++) begin
                burst_cnt[q] = 0;
            end
        end
        for (int q = 0; q < LANES_MAX; q++) begin
            if (done_prev[q]) begin
                assert (!hs_active[q]) else begin
                    $display("hs_active on lane %0d stayed high after its last byte at t=%0t",
                             q, $time);
                    proto_err++;
                end
                done_prev[q] = 1'b0;
            end
            if (fell[q] && exp_mask[q]) begin
                assert (burst_cnt[q] == burst_len(exp_lanes, q)) else begin
                    $display("FAIL t=%0t lane %0d burst byte count: expected %0d, got %0d",
                             $time, q, burst_len(exp_lanes, q), burst_cnt[q]);
                    data_err++;
                end
            end
            if (hs_valid[q] && exp_mask[q]) begin
                assert (exp_rd[q] < exp_wr[q]) else begin
                    $display("lane %0d sent a byte at t=%0t when none was expected", q, $time);
                    data_err++;
                end
                if (exp_rd[q] < exp_wr[q]) begin
                    assert (hs_data[q] == exp_mem[q][exp_rd[q]]) else begin
                        $display("FAIL t=%0t hs_data[%0d]: expected %h, got %h",
                                 $time, q, exp_mem[q][exp_rd[q]], hs_data[q]);
                        data_err++;
                    end
                    exp_rd[q]++;
                    burst_cnt[q]++;
                    if (burst_cnt[q] == burst_len(exp_lanes, q)) begin
                        done_prev[q] = 1'b1;
                    end
                end
            end
        end
        prev_active = hs_active;
    endtask

    // lane outputs checked every cycle once out of reset
    always @(negedge clk_phy) begin
        if (rst_n) begin
            sample_outputs();
        end
    end

    task automatic report_and_finish();
        $display("errors: data %0d, protocol %0d, timeout %0d",
                 data_err, proto_err, timeout_err);
        if (data_err + proto_err + timeout_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        int total_lines;
        total_lines = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_lines += row_lines[r];
        end
        #((total_lines * 200 + 100) * CLK_PERIOD);
        $display("timeout: the packets did not all arrive in time");
        timeout_err++;
        report_and_finish();
    end

    initial begin
        int unsigned seed_val;
        rst_n        = 1'b0;
        enable       = 1'b0;
        lanes_number = 3'd1;
        pix_data     = '0;
        pix_eol      = 1'b0;
        pix_valid    = 1'b0;
        exp_mask     = '0;
        exp_lanes    = 1;
        prev_active  = '0;
        done_prev    = '0;
        data_err     = 0;
        proto_err    = 0;
        timeout_err  = 0;
        for (int i = 0; i < LANES_MAX; i++) begin
            exp_wr[i]    = 0;
            exp_rd[i]    = 0;
            burst_cnt[i] = 0;
        end
        seed_val = $urandom(SEED);
        repeat (4) @(negedge clk_phy);
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        repeat (20) @(negedge clk_phy);   // nothing more may come out
        report_and_finish();
    end

endmodule

`default_nettype wire
